//--- common/safe_pkg.sv
`default_nettype none

package safe_pkg;

  //******************************
  // pad and signal group counts
  //******************************
  localparam int N_IO     = 8;
  localparam int N_PERIO  = 4;
  localparam int N_GPIO   = 8;
  localparam int N_FPGAIO = 4;

  // field widths
  localparam int PADMUX_W  = 2;
  localparam int PADCFG_W  = 6;
  localparam int CLK_DIV_W = 8;
  localparam int PAD_IDX_W = $clog2(N_IO);

  //******************************
  // register port
  //******************************
  localparam int REG_ADDR_W = 4;
  localparam int REG_DATA_W = 16;

  // 0..7 pad entries, 8 control word
  localparam logic [REG_ADDR_W-1:0] CTRL_ADDR = 4'd8;

  // pad source codes
  localparam logic [PADMUX_W-1:0] MUX_GPIO   = 2'd0;
  localparam logic [PADMUX_W-1:0] MUX_PERIO  = 2'd1;
  localparam logic [PADMUX_W-1:0] MUX_FPGAIO = 2'd2;
  localparam logic [PADMUX_W-1:0] MUX_OFF    = 2'd3;

  // one pad, source select plus pad config bits
  typedef struct packed {
    logic [PADMUX_W-1:0] mux;
    logic [PADCFG_W-1:0] cfg;
  } pad_entry_t;

  // pad view of a register word
  typedef struct packed {
    logic [7:0] rsvd;
    pad_entry_t entry;
  } pad_view_t;

  // control view of a register word
  typedef struct packed {
    logic [7:0]           rsvd;
    logic [CLK_DIV_W-1:0] clk_div;
  } ctrl_view_t;

  // same 16 bits, view picked by address
  typedef union packed {
    pad_view_t  pad;
    ctrl_view_t ctrl;
  } reg_word_u;

  // single-cycle write, no back-pressure
  typedef struct packed {
    logic [REG_ADDR_W-1:0] addr;
    reg_word_u             wdata;
    logic                  strobe;
  } reg_wr_t;

endpackage

`default_nettype wire

//--- verilog/rst_sync.sv
`timescale 1ns/1ps
`default_nettype none

module rst_sync (
  input  wire logic ref_clk_i,
  input  wire logic rst_n_i,
  output logic      rst_n_o
);

  // two-flop chain, stage 0 samples constant one
  logic sync_q0;
  logic sync_q1;

  // assert async, release on second edge
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q0 <= 1'b0;
      sync_q1 <= 1'b0;
    end else begin
      sync_q0 <= 1'b1;
      sync_q1 <= sync_q0;
    end
  end

  // every always-on flop sees this release edge
  assign rst_n_o = sync_q1;

endmodule

`default_nettype wire

//--- verilog/slow_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module slow_clk_gen
  import safe_pkg::*;
(
  input  wire logic                 ref_clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic [CLK_DIV_W-1:0] clk_div_i,
  input  wire logic                 restart_i,
  output logic                      slow_clk_o
);

  // down-counter, one terminal count per half period
  logic [CLK_DIV_W-1:0] cnt_q;
  logic                 slow_clk_q;

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q      <= '0;
      slow_clk_q <= 1'b0;
    end else if (restart_i) begin
      // new divider, start a fresh low phase
      cnt_q      <= clk_div_i;
      slow_clk_q <= 1'b0;
    end else if (cnt_q == '0) begin
      // half period done
      cnt_q      <= clk_div_i;
      slow_clk_q <= ~slow_clk_q;
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // straight from a flop, no glitches
  assign slow_clk_o = slow_clk_q;

endmodule

`default_nettype wire

//--- safe_domain/pad_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pad_cfg_regs
  import safe_pkg::*;
(
  input  wire logic                  ref_clk_i,
  input  wire logic                  rst_n_i,

  // write strobe and combinational read port
  input  wire reg_wr_t               reg_wr_i,
  input  wire logic [REG_ADDR_W-1:0] reg_rd_addr_i,
  output logic [REG_DATA_W-1:0]      reg_rdata_o,

  // towards pad mux and divider
  output pad_entry_t [N_IO-1:0]      pad_tbl_o,
  output logic [CLK_DIV_W-1:0]       clk_div_o,
  output logic                       div_restart_o
);

  pad_entry_t [N_IO-1:0] pad_tbl_q;
  logic [CLK_DIV_W-1:0]  clk_div_q;
  logic                  div_restart_q;

  // address decode of the write
  logic      wr_pad;
  logic      wr_ctrl;
  reg_word_u rd_word;

  assign wr_pad  = reg_wr_i.strobe && (reg_wr_i.addr < REG_ADDR_W'(N_IO));
  assign wr_ctrl = reg_wr_i.strobe && (reg_wr_i.addr == CTRL_ADDR);

  //******************************
  // pad entries
  //******************************
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // all pads parked, no drive
      for (int p = 0; p < N_IO; p++) begin
        pad_tbl_q[p].mux <= MUX_OFF;
        pad_tbl_q[p].cfg <= '0;
      end
    end else if (wr_pad) begin
      // pad view of the word
      pad_tbl_q[reg_wr_i.addr[PAD_IDX_W-1:0]] <= reg_wr_i.wdata.pad.entry;
    end
  end

  //******************************
  // control word
  //******************************
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clk_div_q     <= '0;
      div_restart_q <= 1'b0;
    end else begin
      // restart lands one cycle late, divider sees new value
      div_restart_q <= wr_ctrl;
      if (wr_ctrl) begin
        // control view of the word
        clk_div_q <= reg_wr_i.wdata.ctrl.clk_div;
      end
    end
  end

  //******************************
  // read back
  //******************************
  always_comb begin
    // unused addresses read zero
    rd_word = '0;
    if (reg_rd_addr_i < REG_ADDR_W'(N_IO)) begin
      rd_word.pad.entry = pad_tbl_q[reg_rd_addr_i[PAD_IDX_W-1:0]];
    end else if (reg_rd_addr_i == CTRL_ADDR) begin
      rd_word.ctrl.clk_div = clk_div_q;
    end
  end

  assign reg_rdata_o   = rd_word;
  assign pad_tbl_o     = pad_tbl_q;
  assign clk_div_o     = clk_div_q;
  assign div_restart_o = div_restart_q;

endmodule

`default_nettype wire

//--- pad_control/pad_mux.sv
`timescale 1ns/1ps
`default_nettype none

module pad_mux
  import safe_pkg::*;
(
  // per-pad select and config
  input  wire pad_entry_t [N_IO-1:0]        pad_tbl_i,

  // pad side
  output logic [N_IO-1:0]                   io_out_o,
  input  wire logic [N_IO-1:0]              io_in_i,
  output logic [N_IO-1:0]                   io_oe_o,
  output logic [N_IO-1:0][PADCFG_W-1:0]     pad_cfg_o,

  // peripheral group
  input  wire logic [N_PERIO-1:0]           perio_out_i,
  input  wire logic [N_PERIO-1:0]           perio_oe_i,
  output logic [N_PERIO-1:0]                perio_in_o,

  // gpio group
  input  wire logic [N_GPIO-1:0]            gpio_out_i,
  input  wire logic [N_GPIO-1:0]            gpio_oe_i,
  output logic [N_GPIO-1:0]                 gpio_in_o,

  // fpga-side group
  input  wire logic [N_FPGAIO-1:0]          fpgaio_out_i,
  input  wire logic [N_FPGAIO-1:0]          fpgaio_oe_i,
  output logic [N_FPGAIO-1:0]               fpgaio_in_o
);

  //******************************
  // output side, one mux per pad
  //******************************
  for (genvar i = 0; i < N_IO; i++) begin : g_pad
    always_comb begin
      unique case (pad_tbl_i[i].mux)
        MUX_GPIO: begin
          io_out_o[i] = gpio_out_i[i];
          io_oe_o[i]  = gpio_oe_i[i];
        end
        // pads 0..3 and 4..7 share the narrow groups
        MUX_PERIO: begin
          io_out_o[i] = perio_out_i[i % N_PERIO];
          io_oe_o[i]  = perio_oe_i[i % N_PERIO];
        end
        MUX_FPGAIO: begin
          io_out_o[i] = fpgaio_out_i[i % N_FPGAIO];
          io_oe_o[i]  = fpgaio_oe_i[i % N_FPGAIO];
        end
        default: begin
          // MUX_OFF, pad floats
          io_out_o[i] = 1'b0;
          io_oe_o[i]  = 1'b0;
        end
      endcase
    end

    // cfg bits go to the pad untouched
    assign pad_cfg_o[i] = pad_tbl_i[i].cfg;

    // gpio return, one pad per gpio
    assign gpio_in_o[i] = (pad_tbl_i[i].mux == MUX_GPIO) ? io_in_i[i] : 1'b0;
  end

  //******************************
  // input return, low pad wins
  //******************************
  always_comb begin
    perio_in_o  = '0;
    fpgaio_in_o = '0;
    // scan high to low so lower pads overwrite
    for (int p = N_IO - 1; p >= 0; p--) begin
      if (pad_tbl_i[p].mux == MUX_PERIO) begin
        perio_in_o[p % N_PERIO] = io_in_i[p];
      end
      if (pad_tbl_i[p].mux == MUX_FPGAIO) begin
        fpgaio_in_o[p % N_FPGAIO] = io_in_i[p];
      end
    end
  end

endmodule

`default_nettype wire

//--- safe_domain/safe_domain.sv
`timescale 1ns/1ps
`default_nettype none

module safe_domain
  import safe_pkg::*;
(
  input  wire logic                        ref_clk_i,
  input  wire logic                        rst_n_i,
  output logic                             rst_n_o,
  output logic                             slow_clk_o,

  //******************************
  // register port
  //******************************
  input  wire reg_wr_t                     reg_wr_i,
  input  wire logic [REG_ADDR_W-1:0]       reg_rd_addr_i,
  output logic [REG_DATA_W-1:0]            reg_rdata_o,

  //******************************
  // pads
  //******************************
  output logic [N_IO-1:0]                  io_out_o,
  input  wire logic [N_IO-1:0]             io_in_i,
  output logic [N_IO-1:0]                  io_oe_o,
  output logic [N_IO-1:0][PADCFG_W-1:0]    pad_cfg_o,

  // peripherals
  input  wire logic [N_PERIO-1:0]          perio_out_i,
  input  wire logic [N_PERIO-1:0]          perio_oe_i,
  output logic [N_PERIO-1:0]               perio_in_o,

  // gpios
  input  wire logic [N_GPIO-1:0]           gpio_out_i,
  input  wire logic [N_GPIO-1:0]           gpio_oe_i,
  output logic [N_GPIO-1:0]                gpio_in_o,

  // fpga-side signals
  input  wire logic [N_FPGAIO-1:0]         fpgaio_out_i,
  input  wire logic [N_FPGAIO-1:0]         fpgaio_oe_i,
  output logic [N_FPGAIO-1:0]              fpgaio_in_o
);

  // synchronized reset for the whole domain
  logic                  s_rst_n;
  // register block outputs
  pad_entry_t [N_IO-1:0] s_pad_tbl;
  logic [CLK_DIV_W-1:0]  s_clk_div;
  logic                  s_div_restart;

  rst_sync i_rst_sync (
    .ref_clk_i (ref_clk_i),
    .rst_n_i   (rst_n_i),
    .rst_n_o   (s_rst_n)
  );

  // exported for the rest of the chip
  assign rst_n_o = s_rst_n;

  slow_clk_gen i_slow_clk_gen (
    .ref_clk_i  (ref_clk_i),
    .rst_n_i    (s_rst_n),
    .clk_div_i  (s_clk_div),
    .restart_i  (s_div_restart),
    .slow_clk_o (slow_clk_o)
  );

  pad_cfg_regs i_pad_cfg_regs (
    .ref_clk_i     (ref_clk_i),
    .rst_n_i       (s_rst_n),
    .reg_wr_i      (reg_wr_i),
    .reg_rd_addr_i (reg_rd_addr_i),
    .reg_rdata_o   (reg_rdata_o),
    .pad_tbl_o     (s_pad_tbl),
    .clk_div_o     (s_clk_div),
    .div_restart_o (s_div_restart)
  );

  // purely combinational routing
  pad_mux i_pad_mux (
    .pad_tbl_i    (s_pad_tbl),
    .io_out_o     (io_out_o),
    .io_in_i      (io_in_i),
    .io_oe_o      (io_oe_o),
    .pad_cfg_o    (pad_cfg_o),
    .perio_out_i  (perio_out_i),
    .perio_oe_i   (perio_oe_i),
    .perio_in_o   (perio_in_o),
    .gpio_out_i   (gpio_out_i),
    .gpio_oe_i    (gpio_oe_i),
    .gpio_in_o    (gpio_in_o),
    .fpgaio_out_i (fpgaio_out_i),
    .fpgaio_oe_i  (fpgaio_oe_i),
    .fpgaio_in_o  (fpgaio_in_o)
  );

endmodule

`default_nettype wire

//--- test/safe_domain_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module safe_domain_asserts
  import safe_pkg::*;
(
  input wire logic                        ref_clk_i,
  input wire logic                        rst_n_i,
  input wire logic                        rst_n_o,
  input wire logic                        slow_clk_o,
  input wire reg_wr_t                     reg_wr_i,
  input wire logic [REG_ADDR_W-1:0]       reg_rd_addr_i,
  input wire logic [REG_DATA_W-1:0]       reg_rdata_o,
  input wire logic [N_IO-1:0]             io_out_o,
  input wire logic [N_IO-1:0]             io_in_i,
  input wire logic [N_IO-1:0]             io_oe_o,
  input wire logic [N_IO-1:0][PADCFG_W-1:0] pad_cfg_o,
  input wire logic [N_PERIO-1:0]          perio_out_i,
  input wire logic [N_PERIO-1:0]          perio_oe_i,
  input wire logic [N_PERIO-1:0]          perio_in_o,
  input wire logic [N_GPIO-1:0]           gpio_out_i,
  input wire logic [N_GPIO-1:0]           gpio_oe_i,
  input wire logic [N_GPIO-1:0]           gpio_in_o,
  input wire logic [N_FPGAIO-1:0]         fpgaio_out_i,
  input wire logic [N_FPGAIO-1:0]         fpgaio_oe_i,
  input wire logic [N_FPGAIO-1:0]         fpgaio_in_o
);

  // shadow copy of the register bank
  logic [N_IO-1:0][PADMUX_W-1:0] sh_mux;
  logic [N_IO-1:0][PADCFG_W-1:0] sh_cfg;
  logic [7:0]                    sh_div;

  // expected port values
  logic [N_IO-1:0]               exp_out;
  logic [N_IO-1:0]               exp_oe;
  logic [N_GPIO-1:0]             exp_gpio_in;
  logic [N_PERIO-1:0]            exp_perio_in;
  logic [N_FPGAIO-1:0]           exp_fpga_in;
  logic [REG_DATA_W-1:0]         exp_rdata;

  // slow clock edge tracking
  logic        slow_prev;
  logic        rst_pipe1;
  logic        rst_pipe2;
  logic [15:0] gap;
  logic        slow_chg;

  // failures per assertion, summed for the testbench
  int cnt_hold;
  int cnt_rel;
  int cnt_def;
  int cnt_out;
  int cnt_in;
  int cnt_rd;
  int cnt_slow;
  int fail_cnt;

  assign fail_cnt = cnt_hold + cnt_rel + cnt_def + cnt_out + cnt_in + cnt_rd + cnt_slow;

  initial begin
    cnt_hold = 0;
    cnt_rel  = 0;
    cnt_def  = 0;
    cnt_out  = 0;
    cnt_in   = 0;
    cnt_rd   = 0;
    cnt_slow = 0;
  end

  //******************************
  // shadow model
  //******************************
  always_ff @(posedge ref_clk_i or negedge rst_n_o) begin
    if (!rst_n_o) begin
      sh_mux <= {N_IO{MUX_OFF}};
      sh_cfg <= '0;
      sh_div <= '0;
    end else if (reg_wr_i.strobe) begin
      if (reg_wr_i.addr < 4'd8) begin
        // low byte is mux then cfg
        sh_mux[reg_wr_i.addr[2:0]] <= reg_wr_i.wdata[7:6];
        sh_cfg[reg_wr_i.addr[2:0]] <= reg_wr_i.wdata[5:0];
      end else if (reg_wr_i.addr == 4'd8) begin
        sh_div <= reg_wr_i.wdata[7:0];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N_IO; i++) begin
      exp_out[i]     = 1'b0;
      exp_oe[i]      = 1'b0;
      exp_gpio_in[i] = 1'b0;
      if (sh_mux[i] == 2'd0) begin
        exp_out[i]     = gpio_out_i[i];
        exp_oe[i]      = gpio_oe_i[i];
        exp_gpio_in[i] = io_in_i[i];
      end else if (sh_mux[i] == 2'd1) begin
        exp_out[i] = perio_out_i[i & 3];
        exp_oe[i]  = perio_oe_i[i & 3];
      end else if (sh_mux[i] == 2'd2) begin
        exp_out[i] = fpgaio_out_i[i & 3];
        exp_oe[i]  = fpgaio_oe_i[i & 3];
      end
    end
    // pad k first, then k+4, else nothing
    for (int k = 0; k < 4; k++) begin
      if (sh_mux[k] == 2'd1) begin
        exp_perio_in[k] = io_in_i[k];
      end else if (sh_mux[k+4] == 2'd1) begin
        exp_perio_in[k] = io_in_i[k+4];
      end else begin
        exp_perio_in[k] = 1'b0;
      end
      if (sh_mux[k] == 2'd2) begin
        exp_fpga_in[k] = io_in_i[k];
      end else if (sh_mux[k+4] == 2'd2) begin
        exp_fpga_in[k] = io_in_i[k+4];
      end else begin
        exp_fpga_in[k] = 1'b0;
      end
    end
    if (reg_rd_addr_i < 4'd8) begin
      exp_rdata = {8'h00, sh_mux[reg_rd_addr_i[2:0]], sh_cfg[reg_rd_addr_i[2:0]]};
    end else if (reg_rd_addr_i == 4'd8) begin
      exp_rdata = {8'h00, sh_div};
    end else begin
      exp_rdata = '0;
    end
  end

  //******************************
  // slow clock half periods
  //******************************
  // restart reaches the divider one cycle after the write edge
  always_ff @(posedge ref_clk_i or negedge rst_n_o) begin
    if (!rst_n_o) begin
      slow_prev <= 1'b0;
      rst_pipe1 <= 1'b0;
      rst_pipe2 <= 1'b1;
      gap       <= '0;
    end else begin
      slow_prev <= slow_clk_o;
      rst_pipe1 <= reg_wr_i.strobe && (reg_wr_i.addr == 4'd8);
      rst_pipe2 <= rst_pipe1;
      if (rst_pipe2 || slow_chg) gap <= '0;
      else gap <= gap + 16'd1;
    end
  end

  assign slow_chg = (slow_clk_o != slow_prev);

  //******************************
  // assertions
  //******************************
  a_rst_hold: assert property (@(posedge ref_clk_i) !rst_n_i |-> !rst_n_o)
    else begin
      $error("rst_n_o high while rst_n_i low");
      cnt_hold++;
    end

  // second edge after release
  a_rst_release: assert property (@(posedge ref_clk_i)
    $rose(rst_n_i) |-> !rst_n_o ##1 !rst_n_o ##1 rst_n_o)
    else begin
      $error("rst_n_o release not on second edge");
      cnt_rel++;
    end

  a_rst_defaults: assert property (@(posedge ref_clk_i) $rose(rst_n_o) |->
    (io_oe_o == '0 && io_out_o == '0 && pad_cfg_o == '0 && !slow_clk_o))
    else begin
      $error("pad outputs or slow_clk_o not idle after reset");
      cnt_def++;
    end

  a_pad_out: assert property (@(posedge ref_clk_i) disable iff (!rst_n_o)
    io_out_o == exp_out)
    else begin
      $error("CHECK FAILED io_out_o got %h exp %h", $sampled(io_out_o), $sampled(exp_out));
      cnt_out++;
    end

  a_pad_oe: assert property (@(posedge ref_clk_i) disable iff (!rst_n_o)
    io_oe_o == exp_oe)
    else begin
      $error("CHECK FAILED io_oe_o got %h exp %h", $sampled(io_oe_o), $sampled(exp_oe));
      cnt_out++;
    end

  a_pad_cfg: assert property (@(posedge ref_clk_i) disable iff (!rst_n_o)
    pad_cfg_o == sh_cfg)
    else begin
      $error("CHECK FAILED pad_cfg_o got %h exp %h", $sampled(pad_cfg_o), $sampled(sh_cfg));
      cnt_out++;
    end

  a_gpio_in: assert property (@(posedge ref_clk_i) disable iff (!rst_n_o)
    gpio_in_o == exp_gpio_in)
    else begin
      $error("CHECK FAILED gpio_in_o got %h exp %h",
             $sampled(gpio_in_o), $sampled(exp_gpio_in));
      cnt_in++;
    end

  a_perio_in: assert property (@(posedge ref_clk_i) disable iff (!rst_n_o)
    perio_in_o == exp_perio_in)
    else begin
      $error("CHECK FAILED perio_in_o got %h exp %h",
             $sampled(perio_in_o), $sampled(exp_perio_in));
      cnt_in++;
    end

  a_fpga_in: assert property (@(posedge ref_clk_i) disable iff (!rst_n_o)
    fpgaio_in_o == exp_fpga_in)
    else begin
      $error("CHECK FAILED fpgaio_in_o got %h exp %h",
             $sampled(fpgaio_in_o), $sampled(exp_fpga_in));
      cnt_in++;
    end

  a_rdata: assert property (@(posedge ref_clk_i) disable iff (!rst_n_o)
    reg_rdata_o == exp_rdata)
    else begin
      $error("CHECK FAILED reg_rdata_o got %h exp %h",
             $sampled(reg_rdata_o), $sampled(exp_rdata));
      cnt_rd++;
    end

  // gap counts ref edges between toggles, minus one
  a_slow_period: assert property (@(posedge ref_clk_i) disable iff (!rst_n_o)
    (slow_chg && !rst_pipe1 && !rst_pipe2) |-> gap == {8'h00, sh_div})
    else begin
      $error("CHECK FAILED slow_clk_o half period gap got %h exp %h",
             $sampled(gap), $sampled({8'h00, sh_div}));
      cnt_slow++;
    end

endmodule

bind safe_domain safe_domain_asserts u_chk (
  .ref_clk_i     (ref_clk_i),
  .rst_n_i       (rst_n_i),
  .rst_n_o       (rst_n_o),
  .slow_clk_o    (slow_clk_o),
  .reg_wr_i      (reg_wr_i),
  .reg_rd_addr_i (reg_rd_addr_i),
  .reg_rdata_o   (reg_rdata_o),
  .io_out_o      (io_out_o),
  .io_in_i       (io_in_i),
  .io_oe_o       (io_oe_o),
  .pad_cfg_o     (pad_cfg_o),
  .perio_out_i   (perio_out_i),
  .perio_oe_i    (perio_oe_i),
  .perio_in_o    (perio_in_o),
  .gpio_out_i    (gpio_out_i),
  .gpio_oe_i     (gpio_oe_i),
  .gpio_in_o     (gpio_in_o),
  .fpgaio_out_i  (fpgaio_out_i),
  .fpgaio_oe_i   (fpgaio_oe_i),
  .fpgaio_in_o   (fpgaio_in_o)
);

`default_nettype wire

//--- test/tb_safe_domain.sv
`timescale 1ns/1ps
`default_nettype none

module tb_safe_domain;
  import safe_pkg::*;

  // sum of test lengths plus margin
  localparam int CYCLE_LIMIT = 1200;

  logic                            ref_clk_i;
  logic                            rst_n_i;
  logic                            rst_n_o;
  logic                            slow_clk_o;
  reg_wr_t                         reg_wr_i;
  logic [REG_ADDR_W-1:0]           reg_rd_addr_i;
  logic [REG_DATA_W-1:0]           reg_rdata_o;
  logic [N_IO-1:0]                 io_out_o;
  logic [N_IO-1:0]                 io_in_i;
  logic [N_IO-1:0]                 io_oe_o;
  logic [N_IO-1:0][PADCFG_W-1:0]   pad_cfg_o;
  logic [N_PERIO-1:0]              perio_out_i;
  logic [N_PERIO-1:0]              perio_oe_i;
  logic [N_PERIO-1:0]              perio_in_o;
  logic [N_GPIO-1:0]               gpio_out_i;
  logic [N_GPIO-1:0]               gpio_oe_i;
  logic [N_GPIO-1:0]               gpio_in_o;
  logic [N_FPGAIO-1:0]             fpgaio_out_i;
  logic [N_FPGAIO-1:0]             fpgaio_oe_i;
  logic [N_FPGAIO-1:0]             fpgaio_in_o;

  logic [31:0] rng;
  int          cycles;
  int          base_fails;
  int          tests_ok;
  int          tests_bad;

  safe_domain dut0 (.*);

  // 40 ns period
  always #20 ref_clk_i = ~ref_clk_i;

  //******************************
  // timeout
  //******************************
  always @(posedge ref_clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // all tasks start and end just after a falling edge
  task automatic shake_inputs();
    rng          = xorshift32(rng);
    gpio_out_i   = rng[7:0];
    gpio_oe_i    = rng[15:8];
    io_in_i      = rng[23:16];
    perio_out_i  = rng[27:24];
    perio_oe_i   = rng[31:28];
    rng          = xorshift32(rng);
    fpgaio_out_i = rng[3:0];
    fpgaio_oe_i  = rng[7:4];
    reg_rd_addr_i = rng[11:8];
    @(negedge ref_clk_i);
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [15:0] data);
    reg_wr_i.addr   = addr;
    reg_wr_i.wdata  = data;
    reg_wr_i.strobe = 1'b1;
    @(negedge ref_clk_i);
    reg_wr_i.strobe = 1'b0;
  endtask

  // mux code 4 means pick one at random
  task automatic fill_pads(input int mux_code);
    logic [1:0] m;
    for (int p = 0; p < N_IO; p++) begin
      rng = xorshift32(rng);
      m = (mux_code == 4) ? rng[7:6] : 2'(mux_code);
      write_reg(4'(p), {8'h00, m, rng[5:0]});
    end
  endtask

  task automatic pulse_reset();
    rst_n_i = 1'b0;
    repeat (2) @(negedge ref_clk_i);
    rst_n_i = 1'b1;
    while (!rst_n_o) @(negedge ref_clk_i);
    repeat (2) @(negedge ref_clk_i);
  endtask

  task automatic report_test(input string name);
    int n;
    n = dut0.u_chk.fail_cnt - base_fails;
    base_fails = dut0.u_chk.fail_cnt;
    if (n == 0) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d assertion failures", name, n);
      tests_bad++;
    end
  endtask

  initial begin
    ref_clk_i     = 1'b0;
    rst_n_i       = 1'b1;
    reg_wr_i      = '0;
    reg_rd_addr_i = '0;
    io_in_i       = '0;
    perio_out_i   = '0;
    perio_oe_i    = '0;
    gpio_out_i    = '0;
    gpio_oe_i     = '0;
    fpgaio_out_i  = '0;
    fpgaio_oe_i   = '0;
    rng           = 32'hc2355eea;
    cycles        = 0;
    base_fails    = 0;
    tests_ok      = 0;
    tests_bad     = 0;

    // reset from power up, held for two cycles
    #1 rst_n_i = 1'b0;
    repeat (2) @(negedge ref_clk_i);
    rst_n_i = 1'b1;
    while (!rst_n_o) @(negedge ref_clk_i);
    repeat (3) @(negedge ref_clk_i);
    report_test("reset");

    fill_pads(0);
    repeat (16) shake_inputs();
    report_test("gpio_routing");

    for (int r = 0; r < 12; r++) begin
      fill_pads(4);
      repeat (8) shake_inputs();
    end
    report_test("perio_fpgaio_routing");

    fill_pads(4);
    for (int a = 0; a < 16; a++) begin
      reg_rd_addr_i = 4'(a);
      @(negedge ref_clk_i);
    end
    report_test("config_readback");

    // four rising slow clock edges per divider value
    for (int d = 0; d < 3; d++) begin
      int div;
      int edges;
      div = (d == 0) ? 0 : (d == 1) ? 3 : 9;
      write_reg(CTRL_ADDR, 16'(div));
      edges = 0;
      while (edges < 4) begin
        @(posedge slow_clk_o);
        edges++;
      end
      @(negedge ref_clk_i);
    end
    report_test("slow_clock");

    fill_pads(4);
    write_reg(CTRL_ADDR, 16'h0005);
    repeat (4) shake_inputs();
    pulse_reset();
    for (int a = 0; a < 16; a++) begin
      reg_rd_addr_i = 4'(a);
      @(negedge ref_clk_i);
    end
    report_test("reset_mid_run");

    $display("tests ok %0d, failed %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && dut0.u_chk.fail_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
common/safe_pkg.sv
verilog/rst_sync.sv
verilog/slow_clk_gen.sv
safe_domain/pad_cfg_regs.sv
pad_control/pad_mux.sv
safe_domain/safe_domain.sv
test/safe_domain_asserts.sv
test/tb_safe_domain.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_safe_domain
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
	  echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
